// ==== bank_bus_pkg.sv ====
`default_nettype none

package bank_bus_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int ADDR_W   = 16;   // Z80 address bus
    localparam int DATA_W   = 8;
    localparam int PAGE_W   = 6;    // 64 pages of 16 KB
    localparam int BA_W     = 5;    // External bank address
    localparam int KEY_ROWS = 8;

    //////////////////////////////////////////////////
    // Bank registers
    //////////////////////////////////////////////////
    // One bank register, same layout as the I/O byte
    typedef struct packed {
        logic              ro;          // Bit 7, write protect
        logic              overlay;     // Bit 6, system RAM at $3800
        logic [PAGE_W-1:0] page;
    } bank_reg_t;

    // Indexed by CPU address bits 15:14
    typedef bank_reg_t [3:0] bank_set_t;

    // Bank 0 boots into ROM page 0 with overlay on
    localparam bank_set_t BANK_RESET = {
        bank_reg_t'{ro: 1'b0, overlay: 1'b0, page: 6'd19},     // Bank 3
        bank_reg_t'{ro: 1'b0, overlay: 1'b0, page: 6'd34},     // Bank 2
        bank_reg_t'{ro: 1'b0, overlay: 1'b0, page: 6'd33},     // Bank 1
        bank_reg_t'{ro: 1'b1, overlay: 1'b1, page: 6'd0}       // Bank 0
    };

    // Page ranges
    localparam logic [PAGE_W-1:0] PAGE_ROM_LAST   = 6'd3;
    localparam logic [PAGE_W-1:0] PAGE_CART_FIRST = 6'd16;
    localparam logic [PAGE_W-1:0] PAGE_CART_LAST  = 6'd19;
    localparam logic [PAGE_W-1:0] PAGE_RAM_FIRST  = 6'd32;

    //////////////////////////////////////////////////
    // I/O map
    //////////////////////////////////////////////////
    localparam logic [7:0] IO_BANK0       = 8'hF0;
    localparam logic [7:0] IO_BANK1       = 8'hF1;
    localparam logic [7:0] IO_BANK2       = 8'hF2;
    localparam logic [7:0] IO_BANK3       = 8'hF3;
    localparam logic [7:0] IO_SYSCTRL     = 8'hFB;
    localparam logic [7:0] IO_CASSETTE    = 8'hFC;
    localparam logic [7:0] IO_PRINTER     = 8'hFE;
    localparam logic [7:0] IO_KEYB        = 8'hFF;
    localparam logic [7:0] IO_KEYROW_BASE = 8'h00;  // Host only, $00-$07

    // Address bits 13:11 of system RAM inside an overlay bank
    localparam logic [2:0] SYSRAM_SEL = 3'b111;

    // Who owns the register bus this cycle
    typedef enum logic {
        INIT_CPU,
        INIT_HOST
    } initiator_t;

    typedef enum logic [1:0] {
        ARB_IDLE,   // Nothing pending
        ARB_CPU,    // Host waiting on a CPU I/O cycle
        ARB_HOST    // Host access on the bus
    } arb_state_t;

endpackage

`default_nettype wire

// ==== reg_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if import bank_bus_pkg::*; ();

    logic              strobe_wr;   // One cycle, commits on this edge
    logic              strobe_rd;
    initiator_t        initiator;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wrdata;
    logic [DATA_W-1:0] rddata;      // Combinational from addr
    logic              hit;         // Register exists and is visible

    modport master (
        output strobe_wr, strobe_rd, initiator, addr, wrdata,
        input  rddata, hit
    );

    modport slave (
        input  strobe_wr, strobe_rd, initiator, addr, wrdata,
        output rddata, hit
    );

endinterface

`default_nettype wire

// ==== bus_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_sync import bank_bus_pkg::*; (
    input  logic              sysclk,
    input  logic              reset,
    input  logic              rd_n,
    input  logic              wr_n,
    input  logic              iorq_n,
    input  logic [DATA_W-1:0] d_in,
    output logic              cpu_rd,
    output logic              cpu_wr,
    output logic [DATA_W-1:0] cpu_wrdata,
    output logic              io_cycle
);

    logic [2:0] rd_sync;
    logic [2:0] wr_sync;
    logic [1:0] iorq_sync;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_sync   <= '1;
            wr_sync   <= '1;
            iorq_sync <= '1;
            cpu_rd    <= 1'b0;
            cpu_wr    <= 1'b0;
        end else begin
            rd_sync   <= {rd_sync[1:0], rd_n};
            wr_sync   <= {wr_sync[1:0], wr_n};
            iorq_sync <= {iorq_sync[0], iorq_n};
            cpu_rd    <= rd_sync[2] & ~rd_sync[1];     // Falling edge
            cpu_wr    <= wr_sync[2] & ~wr_sync[1];
        end
    end

    // IORQ is one stage shorter, so io_cycle leads the strobe pulses
    assign io_cycle = ~iorq_sync[1];

    // Z80 holds data stable for the whole write strobe
    always_ff @(posedge sysclk) begin
        if (!wr_n) begin
            cpu_wrdata <= d_in;
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge sysclk) disable iff (reset)
        !(cpu_rd && cpu_wr));

endmodule

`default_nettype wire

// ==== mem_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_decoder import bank_bus_pkg::*; (
    input  logic [ADDR_W-1:0] addr,
    input  logic              mreq_n,
    input  logic              wr_n,
    input  bank_set_t         banks,
    output logic [BA_W-1:0]   ba,
    output logic              rom_ce_n,
    output logic              cart_ce_n,
    output logic              ram_ce_n,
    output logic              ram_we_n
);

    bank_reg_t bank;
    logic      mem;
    logic      sel_sysram;
    logic      page_rom;
    logic      page_cart;
    logic      page_ram;
    logic      wr_blocked;
    logic      sel_ram;

    assign bank = banks[addr[15:14]];      // One register per 16 KB window
    assign mem  = !mreq_n;

    //////////////////////////////////////////////////
    // System RAM overlay
    //////////////////////////////////////////////////
    // $3800-$3FFF of an overlay bank, always page 32
    assign sel_sysram = mem && bank.overlay && addr[13:11] == SYSRAM_SEL;

    //////////////////////////////////////////////////
    // Page decode
    //////////////////////////////////////////////////
    assign page_rom  = bank.page <= PAGE_ROM_LAST;
    assign page_cart = bank.page >= PAGE_CART_FIRST && bank.page <= PAGE_CART_LAST;
    assign page_ram  = bank.page >= PAGE_RAM_FIRST;

    // Writes into a protected bank select nothing
    assign wr_blocked = !wr_n && bank.ro;

    assign sel_ram = sel_sysram || (mem && page_ram && !wr_blocked);

    assign rom_ce_n  = !(mem && page_rom && !sel_sysram);
    assign cart_ce_n = !(mem && page_cart && !sel_sysram && !wr_blocked);
    assign ram_ce_n  = !sel_ram;
    assign ram_we_n  = !(sel_ram && !wr_n);    // Overlay ignores ro

    assign ba = sel_sysram ? '0 : bank.page[BA_W-1:0];

endmodule

`default_nettype wire

// ==== io_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_arbiter import bank_bus_pkg::*; (
    input  logic              sysclk,
    input  logic              reset,
    input  logic              cpu_rd,
    input  logic              cpu_wr,
    input  logic [DATA_W-1:0] cpu_wrdata,
    input  logic              io_cycle,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic              rd_n,
    input  logic              host_wr,
    input  logic              host_rd,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [DATA_W-1:0] host_wrdata,
    output logic [DATA_W-1:0] host_rddata,
    output logic              host_done,
    output logic [DATA_W-1:0] d_out,
    output logic              d_oe,
    reg_bus_if.master         bus
);

    arb_state_t        state;
    logic              host_req;
    logic              cpu_io_rd;
    logic              cpu_io_wr;
    logic              grant;
    logic              req_wr;       // Pending request is a write
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wrdata;

    assign host_req = host_wr | host_rd;
    assign grant    = state == ARB_HOST;

    // Memory cycles also toggle the strobes, keep only I/O ones
    assign cpu_io_rd = cpu_rd & io_cycle;
    assign cpu_io_wr = cpu_wr & io_cycle;

    //////////////////////////////////////////////////
    // Host request FSM
    //////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            state     <= ARB_IDLE;
            host_done <= 1'b0;
        end else begin
            host_done <= grant;                 // One cycle after grant
            case (state)
                ARB_IDLE: begin
                    if (host_req) begin
                        state <= io_cycle ? ARB_CPU : ARB_HOST;
                    end
                end
                ARB_CPU: begin
                    if (!io_cycle) begin
                        state <= ARB_HOST;
                    end
                end
                default: state <= ARB_IDLE;     // ARB_HOST lasts one cycle
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (host_req && state == ARB_IDLE) begin
            req_wr     <= host_wr;
            req_addr   <= host_addr;
            req_wrdata <= host_wrdata;
        end
        if (grant) begin
            host_rddata <= bus.rddata;
        end
    end

    //////////////////////////////////////////////////
    // Register bus mux
    //////////////////////////////////////////////////
    assign bus.strobe_wr = grant ? req_wr      : cpu_io_wr;
    assign bus.strobe_rd = grant ? !req_wr     : cpu_io_rd;
    assign bus.initiator = grant ? INIT_HOST   : INIT_CPU;
    assign bus.addr      = grant ? req_addr    : cpu_addr;
    assign bus.wrdata    = grant ? req_wrdata  : cpu_wrdata;

    // CPU read path, dropped for the single host cycle
    assign d_out = bus.rddata;
    assign d_oe  = io_cycle && !rd_n && bus.hit && !grant;

    // Grant is decided with io_cycle low, which leads any CPU strobe
    a_grant_no_cpu: assert property (@(posedge sysclk) disable iff (reset)
        grant |-> !(cpu_io_rd || cpu_io_wr));

    a_one_pending: assert property (@(posedge sysclk) disable iff (reset)
        host_req |-> state == ARB_IDLE);

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_regs import bank_bus_pkg::*; (
    input  logic      sysclk,
    input  logic      reset,
    input  logic      cassette_in,
    input  logic      printer_in,
    output bank_set_t banks,
    output logic      cassette_out,
    output logic      printer_out,
    reg_bus_if.slave  bus
);

    logic [7:0]                       port;
    logic                             hide_regs;   // Sysctrl bit 0
    logic                             dis_sound;   // Sysctrl bit 1, storage only
    logic [KEY_ROWS-1:0][DATA_W-1:0]  key_rows;
    logic [DATA_W-1:0]                key_and;
    logic                             key_sel;
    logic [2:0]                       cassette_sync;
    logic [2:0]                       printer_sync;

    assign port = bus.addr[7:0];

    // Key rows exist only for the host
    assign key_sel = bus.initiator == INIT_HOST && port[7:3] == IO_KEYROW_BASE[7:3];

    always_ff @(posedge sysclk) begin
        cassette_sync <= {cassette_sync[1:0], cassette_in};
        printer_sync  <= {printer_sync[1:0], printer_in};
    end

    //////////////////////////////////////////////////
    // Key matrix, high address byte selects rows
    //////////////////////////////////////////////////
    always_comb begin
        key_and = '1;
        for (int r = 0; r < KEY_ROWS; r++) begin
            if (!bus.addr[8 + r]) begin
                key_and &= key_rows[r];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read mux and hit
    //////////////////////////////////////////////////
    always_comb begin
        bus.rddata = '1;
        bus.hit    = 1'b0;
        case (port)
            IO_BANK0, IO_BANK1, IO_BANK2, IO_BANK3: begin
                bus.hit    = !hide_regs;
                bus.rddata = banks[port[1:0]];
            end
            IO_SYSCTRL: begin
                bus.hit    = 1'b1;
                bus.rddata = {6'b0, dis_sound, hide_regs};
            end
            IO_CASSETTE: begin
                bus.hit    = 1'b1;
                bus.rddata = {7'b0, ~cassette_sync[2]};   // Inverted input
            end
            IO_PRINTER: begin
                bus.hit    = 1'b1;
                bus.rddata = {7'b0, printer_sync[2]};
            end
            IO_KEYB: begin
                bus.hit    = 1'b1;
                bus.rddata = key_and;
            end
            default: begin
                if (key_sel) begin
                    bus.hit    = 1'b1;
                    bus.rddata = key_rows[port[2:0]];
                end
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks        <= BANK_RESET;
            hide_regs    <= 1'b0;
            dis_sound    <= 1'b0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
            key_rows     <= '1;                 // All keys released
        end else if (bus.strobe_wr && bus.hit) begin
            case (port)
                IO_BANK0, IO_BANK1, IO_BANK2, IO_BANK3: begin
                    banks[port[1:0]] <= bank_reg_t'(bus.wrdata);
                end
                IO_SYSCTRL:  {dis_sound, hide_regs} <= bus.wrdata[1:0];
                IO_CASSETTE: cassette_out <= bus.wrdata[0];
                IO_PRINTER:  printer_out  <= bus.wrdata[0];
                default: begin
                    if (key_sel) begin
                        key_rows[port[2:0]] <= bus.wrdata;
                    end
                end
            endcase
        end
    end

    // The arbiter never mixes a CPU and a host strobe on the bus
    a_single_strobe: assert property (@(posedge sysclk) disable iff (reset)
        !(bus.strobe_wr && bus.strobe_rd));

endmodule

`default_nettype wire

// ==== bank_bus_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_bus_top import bank_bus_pkg::*; (
    input  logic              sysclk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] d_in,
    input  logic              rd_n,
    input  logic              wr_n,
    input  logic              mreq_n,
    input  logic              iorq_n,
    input  logic              cassette_in,
    input  logic              printer_in,
    input  logic              host_wr,
    input  logic              host_rd,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [DATA_W-1:0] host_wrdata,
    output logic [DATA_W-1:0] d_out,
    output logic              d_oe,
    output logic [BA_W-1:0]   ba,
    output logic              rom_ce_n,
    output logic              cart_ce_n,
    output logic              ram_ce_n,
    output logic              ram_we_n,
    output logic              cassette_out,
    output logic              printer_out,
    output logic [DATA_W-1:0] host_rddata,
    output logic              host_done
);

    logic              cpu_rd;
    logic              cpu_wr;
    logic [DATA_W-1:0] cpu_wrdata;
    logic              io_cycle;
    bank_set_t         banks;

    reg_bus_if bus_i ();

    //////////////////////////////////////////////////
    // CPU side
    //////////////////////////////////////////////////
    bus_sync bus_sync_i (
        .sysclk     (sysclk),
        .reset      (reset),
        .rd_n       (rd_n),
        .wr_n       (wr_n),
        .iorq_n     (iorq_n),
        .d_in       (d_in),
        .cpu_rd     (cpu_rd),
        .cpu_wr     (cpu_wr),
        .cpu_wrdata (cpu_wrdata),
        .io_cycle   (io_cycle)
    );

    mem_decoder mem_decoder_i (
        .addr      (addr),
        .mreq_n    (mreq_n),
        .wr_n      (wr_n),
        .banks     (banks),
        .ba        (ba),
        .rom_ce_n  (rom_ce_n),
        .cart_ce_n (cart_ce_n),
        .ram_ce_n  (ram_ce_n),
        .ram_we_n  (ram_we_n)
    );

    //////////////////////////////////////////////////
    // Register bus
    //////////////////////////////////////////////////
    io_arbiter io_arbiter_i (
        .sysclk      (sysclk),
        .reset       (reset),
        .cpu_rd      (cpu_rd),
        .cpu_wr      (cpu_wr),
        .cpu_wrdata  (cpu_wrdata),
        .io_cycle    (io_cycle),
        .cpu_addr    (addr),
        .rd_n        (rd_n),
        .host_wr     (host_wr),
        .host_rd     (host_rd),
        .host_addr   (host_addr),
        .host_wrdata (host_wrdata),
        .host_rddata (host_rddata),
        .host_done   (host_done),
        .d_out       (d_out),
        .d_oe        (d_oe),
        .bus         (bus_i)
    );

    io_regs io_regs_i (
        .sysclk       (sysclk),
        .reset        (reset),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .banks        (banks),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .bus          (bus_i)
    );

endmodule

`default_nettype wire

// ==== tb_bank_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_bank_bus import bank_bus_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DLY   = 2;       // Inputs change after the rising edge
    localparam int STROBE_CYC  = 6;
    localparam int IDLE_CYC    = 3;       // Lets the strobe synchronizers settle
    localparam int TIMEOUT_CYC = 4000;    // Full run is roughly 900 cycles

    typedef struct packed {
        logic [BA_W-1:0] ba;
        logic            rom_ce_n;
        logic            cart_ce_n;
        logic            ram_ce_n;
        logic            ram_we_n;
    } decode_t;

    typedef struct packed {
        logic              hit;
        logic [DATA_W-1:0] data;
    } io_resp_t;

    typedef enum logic [1:0] {
        CHK_CPU_RD,
        CHK_HOST_RD,
        CHK_DECODE,
        CHK_PINS
    } chk_kind_t;

    typedef struct packed {
        chk_kind_t         kind;
        logic [ADDR_W-1:0] addr;
        logic              mreq_n;
        logic              wr_n;
    } check_req_t;

    logic              sysclk;
    logic              reset;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] d_in;
    logic              rd_n;
    logic              wr_n;
    logic              mreq_n;
    logic              iorq_n;
    logic              cassette_in;
    logic              printer_in;
    logic              host_wr;
    logic              host_rd;
    logic [ADDR_W-1:0] host_addr;
    logic [DATA_W-1:0] host_wrdata;
    logic [DATA_W-1:0] d_out;
    logic              d_oe;
    logic [BA_W-1:0]   ba;
    logic              rom_ce_n;
    logic              cart_ce_n;
    logic              ram_ce_n;
    logic              ram_we_n;
    logic              cassette_out;
    logic              printer_out;
    logic [DATA_W-1:0] host_rddata;
    logic              host_done;

    // Reference model state
    bank_set_t                     m_banks;
    logic                          m_hide;
    logic                          m_sound;
    logic                          m_cass;
    logic                          m_prn;
    logic [7:0][DATA_W-1:0]        m_keys;

    logic [31:0] lcg_state = 32'h967f;
    check_req_t  check_q[$];
    event        check_ev;
    int          error_count = 0;
    int          cycle_count;

    bank_bus_top dut_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYC) begin
            @(posedge sysclk);
            cycle_count++;
        end
        $display("ERROR: test did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic [7:0] random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic decode_t ref_decode(input logic [ADDR_W-1:0] a, input logic mreq_v,
                                           input logic wr_v);
        bank_reg_t b;
        logic      blocked;
        decode_t   d;
        b           = m_banks[a[15:14]];
        blocked     = !wr_v && b.ro;
        d.ba        = b.page[BA_W-1:0];
        d.rom_ce_n  = 1'b1;
        d.cart_ce_n = 1'b1;
        d.ram_ce_n  = 1'b1;
        d.ram_we_n  = 1'b1;
        if (!mreq_v) begin
            if (b.overlay && a[13:11] == SYSRAM_SEL) begin   // System RAM, ro ignored
                d.ba       = '0;
                d.ram_ce_n = 1'b0;
                d.ram_we_n = wr_v;
            end else if (b.page <= PAGE_ROM_LAST) begin
                d.rom_ce_n = 1'b0;
            end else if (b.page >= PAGE_CART_FIRST && b.page <= PAGE_CART_LAST) begin
                d.cart_ce_n = blocked;
            end else if (b.page >= PAGE_RAM_FIRST) begin
                d.ram_ce_n = blocked;
                d.ram_we_n = blocked || wr_v;
            end
        end
        return d;
    endfunction

    function automatic io_resp_t ref_io_read(input logic [ADDR_W-1:0] a, input initiator_t who);
        io_resp_t r;
        r.hit  = 1'b1;
        r.data = '1;
        case (a[7:0])
            IO_BANK0, IO_BANK1, IO_BANK2, IO_BANK3: begin
                r.hit  = !m_hide;
                r.data = m_banks[a[1:0]];
            end
            IO_SYSCTRL:  r.data = {6'b0, m_sound, m_hide};
            IO_CASSETTE: r.data = {7'b0, !cassette_in};
            IO_PRINTER:  r.data = {7'b0, printer_in};
            IO_KEYB: begin
                for (int k = 0; k < 8; k++) begin
                    if (!a[8 + k]) r.data &= m_keys[k];    // Low mask bit selects the row
                end
            end
            default: begin
                r.hit  = who == INIT_HOST && a[7:3] == 5'b0;
                r.data = m_keys[a[2:0]];
            end
        endcase
        return r;
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                                        input initiator_t who);
        case (a[7:0])
            IO_BANK0, IO_BANK1, IO_BANK2, IO_BANK3: begin
                if (!m_hide) m_banks[a[1:0]] = bank_reg_t'(d);
            end
            IO_SYSCTRL:  {m_sound, m_hide} = d[1:0];
            IO_CASSETTE: m_cass = d[0];
            IO_PRINTER:  m_prn = d[0];
            default: begin
                if (who == INIT_HOST && a[7:3] == 5'b0) m_keys[a[2:0]] = d;
            end
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic fail_stop(input string msg);
        error_count++;
        $display("FAILED at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_byte(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) fail_stop($sformatf("%s is %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) fail_stop($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_bank(input string what, input bank_reg_t got, input bank_reg_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("%s ro=%b ov=%b page=%0d, expected ro=%b ov=%b page=%0d",
                what, got.ro, got.overlay, got.page, exp.ro, exp.overlay, exp.page));
        end
    endtask

    task automatic check_decode(input logic [ADDR_W-1:0] a, input decode_t got,
                                input decode_t exp);
        if (got !== exp) begin
            fail_stop($sformatf({"decode at %04h ba=%0d rom/cart/ram/we=%b%b%b%b,",
                " expected ba=%0d rom/cart/ram/we=%b%b%b%b"}, a, got.ba, got.rom_ce_n,
                got.cart_ce_n, got.ram_ce_n, got.ram_we_n, exp.ba, exp.rom_ce_n,
                exp.cart_ce_n, exp.ram_ce_n, exp.ram_we_n));
        end
    endtask

    // Comparing process, runs at the negedge where a request was queued
    initial begin
        check_req_t        req;
        io_resp_t          exp_io;
        logic [DATA_W-1:0] got;
        forever begin
            @(check_ev);
            while (check_q.size() > 0) begin
                req = check_q.pop_front();
                case (req.kind)
                    CHK_DECODE: begin
                        check_decode(req.addr, {ba, rom_ce_n, cart_ce_n, ram_ce_n, ram_we_n},
                                     ref_decode(req.addr, req.mreq_n, req.wr_n));
                    end
                    CHK_PINS: begin
                        check_flag("cassette_out", cassette_out, m_cass);
                        check_flag("printer_out", printer_out, m_prn);
                    end
                    default: begin
                        exp_io = ref_io_read(req.addr,
                                             req.kind == CHK_HOST_RD ? INIT_HOST : INIT_CPU);
                        got    = req.kind == CHK_HOST_RD ? host_rddata : d_out;
                        if (req.kind == CHK_CPU_RD) check_flag("d_oe", d_oe, exp_io.hit);
                        if (exp_io.hit && req.addr[7:2] == IO_BANK0[7:2]) begin
                            check_bank($sformatf("bank at %04h", req.addr), got, exp_io.data);
                        end else if (exp_io.hit) begin
                            check_byte($sformatf("read of %04h", req.addr), got, exp_io.data);
                        end
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////
    task automatic next_drive_slot();
        @(posedge sysclk);
        #DRIVE_DLY;
    endtask

    task automatic request_check(input chk_kind_t kind, input logic [ADDR_W-1:0] a,
                                 input logic mreq_v, input logic wr_v);
        check_q.push_back('{kind: kind, addr: a, mreq_n: mreq_v, wr_n: wr_v});
        -> check_ev;
    endtask

    task automatic cpu_io_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        next_drive_slot();
        addr   = a;
        d_in   = d;
        iorq_n = 1'b0;
        wr_n   = 1'b0;
        repeat (STROBE_CYC) next_drive_slot();
        iorq_n = 1'b1;
        wr_n   = 1'b1;
        repeat (IDLE_CYC) next_drive_slot();
        model_write(a, d, INIT_CPU);
    endtask

    task automatic cpu_io_read(input logic [ADDR_W-1:0] a);
        next_drive_slot();
        addr   = a;
        iorq_n = 1'b0;
        rd_n   = 1'b0;
        repeat (STROBE_CYC - 1) next_drive_slot();
        @(negedge sysclk);
        request_check(CHK_CPU_RD, a, 1'b1, 1'b1);
        next_drive_slot();
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        repeat (IDLE_CYC) next_drive_slot();
    endtask

    task automatic host_access(input logic wr, input logic [ADDR_W-1:0] a,
                               input logic [DATA_W-1:0] d);
        next_drive_slot();
        host_addr   = a;
        host_wrdata = d;
        host_wr     = wr;
        host_rd     = !wr;
        next_drive_slot();
        host_wr = 1'b0;       // One strobe per request
        host_rd = 1'b0;
        @(negedge sysclk);
        while (!host_done) @(negedge sysclk);
        if (wr) model_write(a, d, INIT_HOST);
        else request_check(CHK_HOST_RD, a, 1'b1, 1'b1);
    endtask

    task automatic mem_check(input logic [ADDR_W-1:0] a, input logic mreq_v, input logic wr_v);
        next_drive_slot();
        addr   = a;
        mreq_n = mreq_v;
        wr_n   = wr_v;
        @(negedge sysclk);
        request_check(CHK_DECODE, a, mreq_v, wr_v);
    endtask

    task automatic bus_quiet();
        next_drive_slot();
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        repeat (4) next_drive_slot();
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [7:0]        r;
        logic [7:0]        val;
        logic [ADDR_W-1:0] a;
        reset       = 1'b1;
        addr        = '0;
        d_in        = '0;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        host_wr     = 1'b0;
        host_rd     = 1'b0;
        host_addr   = '0;
        host_wrdata = '0;
        m_banks[0]  = bank_reg_t'(8'hC0);   // Page 0, ro and overlay
        m_banks[1]  = bank_reg_t'(8'd33);
        m_banks[2]  = bank_reg_t'(8'd34);
        m_banks[3]  = bank_reg_t'(8'd19);
        m_hide      = 1'b0;
        m_sound     = 1'b0;
        m_cass      = 1'b0;
        m_prn       = 1'b0;
        m_keys      = '1;
        repeat (10) @(posedge sysclk);
        #DRIVE_DLY reset = 1'b0;

        // Reset state and idle enables
        for (int i = 0; i < 4; i++) cpu_io_read({8'h00, IO_BANK0[7:2], 2'(i)});
        mem_check(16'h0000, 1'b0, 1'b1);
        mem_check(16'h0000, 1'b1, 1'b1);
        mem_check(16'h9234, 1'b1, 1'b0);
        bus_quiet();

        // Random bank contents against the decode rules
        for (int n = 0; n < 12; n++) begin
            r = random_byte();
            cpu_io_write({random_byte(), IO_BANK0[7:2], r[1:0]}, random_byte());
            for (int k = 0; k < 4; k++) begin
                val = random_byte();
                mem_check({r[1:0], val[5:0], random_byte()}, 1'b0, val[7]);
            end
            bus_quiet();
        end
        cpu_io_write(16'h00F1, 8'h80 | 8'd40);    // Read-only RAM
        cpu_io_write(16'h00F3, 8'h80 | 8'd17);    // Read-only cartridge
        mem_check(16'h4123, 1'b0, 1'b0);
        mem_check(16'h4123, 1'b0, 1'b1);
        mem_check(16'hC456, 1'b0, 1'b0);
        mem_check(16'hC456, 1'b0, 1'b1);
        bus_quiet();

        // Overlay on a read-only ROM bank
        cpu_io_write(16'h00F2, 8'hC2);
        mem_check(16'hB800, 1'b0, 1'b0);
        mem_check(16'hBFFF, 1'b0, 1'b1);
        mem_check(16'hB7FF, 1'b0, 1'b0);
        mem_check(16'h3A00, 1'b0, 1'b0);
        bus_quiet();

        // Key matrix
        for (int i = 0; i < 8; i++) host_access(1'b1, {13'b0, 3'(i)}, random_byte());
        cpu_io_read({8'hFF, IO_KEYB});
        cpu_io_read({8'h00, IO_KEYB});
        for (int n = 0; n < 8; n++) cpu_io_read({random_byte(), IO_KEYB});
        cpu_io_write({random_byte(), 8'h03}, random_byte());    // CPU cannot write rows
        host_access(1'b0, 16'h0003, 8'h00);
        cpu_io_read(16'h0003);

        // Hide bit and single-bit ports
        cpu_io_write({8'h00, IO_SYSCTRL}, 8'h01);
        for (int i = 0; i < 4; i++) cpu_io_read({8'h00, IO_BANK0[7:2], 2'(i)});
        cpu_io_read({8'h00, IO_SYSCTRL});
        for (int n = 0; n < 3; n++) begin
            next_drive_slot();
            r           = random_byte();
            cassette_in = r[0];
            printer_in  = r[1];
            cpu_io_write({8'h00, IO_CASSETTE}, random_byte());
            cpu_io_write({8'h00, IO_PRINTER}, random_byte());
            @(negedge sysclk);
            request_check(CHK_PINS, 16'h0000, 1'b1, 1'b1);
            cpu_io_read({8'h00, IO_CASSETTE});
            cpu_io_read({8'h00, IO_PRINTER});
        end
        cpu_io_write({8'h00, IO_SYSCTRL}, 8'h02);
        cpu_io_read({8'h00, IO_SYSCTRL});

        // Host reads racing CPU I/O cycles
        for (int n = 0; n < 10; n++) begin
            r = random_byte();
            a = {8'h00, IO_BANK0[7:2], r[5:4]};
            fork
                cpu_io_read({8'h00, IO_BANK0[7:2], r[1:0]});
                begin
                    repeat (r[3:0] % 12) next_drive_slot();
                    host_access(1'b0, a, 8'h00);
                end
            join
        end

        repeat (4) next_drive_slot();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bank_bus.f ====
bank_bus_pkg.sv
reg_bus_if.sv
bus_sync.sv
mem_decoder.sv
io_arbiter.sv
io_regs.sv
bank_bus_top.sv
tb_bank_bus.sv

// ==== Makefile ====
# Verilator build and run for bank_bus

VERILATOR ?= verilator
TOP       ?= tb_bank_bus
FLIST     ?= bank_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
FAIL_MSG  ?= FAIL: see errors above

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
